//--- design/cam_params.svh
`ifndef CAM_PARAMS_SVH
`define CAM_PARAMS_SVH

// Number of CAM entries
`define CAM_DEPTH 16

// Width of one stored word
`define CAM_DATA_W 64

// Search key taken from the low bits of the stored word
`define CAM_KEY_W 16

// Location index width is log2 of the depth
`define CAM_LOC_W 4

`endif

//--- design/cam_pkg.sv
`include "cam_params.svh"

package cam_pkg;

	typedef logic [`CAM_LOC_W-1:0] cam_loc_t;

	typedef logic [`CAM_KEY_W-1:0] cam_key_t;

	typedef logic [`CAM_DATA_W-1:0] cam_data_t;

	// Whole entry storage as one packed array with index 0 at the bottom
	typedef logic [`CAM_DEPTH-1:0][`CAM_DATA_W-1:0] cam_entries_t;

	// Start-up counter first, then only recirculated locations
	typedef enum logic {
		ALLOC_START,
		ALLOC_RECIRC
	} alloc_phase_t;

endpackage

//--- design/cam_free_fifo.sv
`timescale 1ns/10ps
`include "cam_params.svh"

module cam_free_fifo (
	input  logic             clk,
	input  logic             rst_an,
	input  logic             push,
	input  cam_pkg::cam_loc_t push_loc,
	input  logic             pop,
	output logic             not_empty,
	output cam_pkg::cam_loc_t head_loc
);

	import cam_pkg::*;

	cam_loc_t                 mem [`CAM_DEPTH];
	cam_loc_t                 rd_ptr;
	cam_loc_t                 wr_ptr;
	logic [`CAM_LOC_W:0]      count;
	logic                     full;

	// Depth is a power of two, so the pointers wrap on their own
	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= push_loc;
		end
	end

	always_ff @(posedge clk or negedge rst_an) begin
		if (!rst_an) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign not_empty = (count != '0);
	assign full = (count == (`CAM_LOC_W+1)'(`CAM_DEPTH));
	assign head_loc = mem[rd_ptr];

	// ==============================
	// A full FIFO means every entry is free, so no snoop can hit
	a_no_push_full: assert property (@(posedge clk) disable iff (!rst_an)
		push |-> !full);

	a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_an)
		pop |-> not_empty);

endmodule

//--- design/cam_loc_alloc.sv
`timescale 1ns/10ps
`include "cam_params.svh"

module cam_loc_alloc (
	input  logic             clk,
	input  logic             rst_an,
	input  logic             wr_valid,
	output logic             wr_ready,
	output logic             alloc_en,
	output cam_pkg::cam_loc_t alloc_loc,
	input  logic             free_en,
	input  cam_pkg::cam_loc_t free_loc
);

	import cam_pkg::*;

	alloc_phase_t phase;
	cam_loc_t     start_cnt;
	logic         fifo_pop;
	logic         fifo_not_empty;
	cam_loc_t     fifo_head;

	// Freed locations go into the FIFO in both phases
	cam_free_fifo cam_free_fifo_inst (
		.clk       (clk),
		.rst_an    (rst_an),
		.push      (free_en),
		.push_loc  (free_loc),
		.pop       (fifo_pop),
		.not_empty (fifo_not_empty),
		.head_loc  (fifo_head)
	);

	// ==============================
	// The counter hands out every location once, then the FIFO takes over
	always_ff @(posedge clk or negedge rst_an) begin
		if (!rst_an) begin
			phase <= ALLOC_START;
			start_cnt <= '0;
		end else if (alloc_en && phase == ALLOC_START) begin
			start_cnt <= start_cnt + 1'b1;
			if (start_cnt == cam_loc_t'(`CAM_DEPTH - 1)) begin
				phase <= ALLOC_RECIRC;
			end
		end
	end

	assign wr_ready = (phase == ALLOC_START) | fifo_not_empty;
	assign alloc_en = wr_valid & wr_ready;
	assign alloc_loc = (phase == ALLOC_START) ? start_cnt : fifo_head;
	assign fifo_pop = alloc_en & (phase == ALLOC_RECIRC);

	// A stalled write stays requested until a location frees up
	a_wr_held_while_stalled: assert property (@(posedge clk) disable iff (!rst_an)
		wr_valid && !wr_ready |=> wr_valid);

endmodule

//--- design/cam_entry_array.sv
`timescale 1ns/10ps
`include "cam_params.svh"

module cam_entry_array (
	input  logic                  clk,
	input  logic                  rst_an,
	input  logic                  alloc_en,
	input  cam_pkg::cam_loc_t      alloc_loc,
	input  cam_pkg::cam_data_t     wr_data,
	input  logic                  free_en,
	input  cam_pkg::cam_loc_t      free_loc,
	output cam_pkg::cam_entries_t  entries,
	output logic [`CAM_DEPTH-1:0] entry_valid
);

	// ==============================
	// Word storage
	always_ff @(posedge clk or negedge rst_an) begin
		if (!rst_an) begin
			entries <= '0;
		end else if (alloc_en) begin
			entries[alloc_loc] <= wr_data;
		end
	end

	// Valid bits. Allocation only reaches free entries and a hit only valid ones,
	// so the set and the clear never land on the same bit
	always_ff @(posedge clk or negedge rst_an) begin
		if (!rst_an) begin
			entry_valid <= '0;
		end else begin
			if (alloc_en) begin
				entry_valid[alloc_loc] <= 1'b1;
			end
			if (free_en) begin
				entry_valid[free_loc] <= 1'b0;
			end
		end
	end

	// The allocator and the snoop path together must keep free and valid apart
	a_alloc_free_entry: assert property (@(posedge clk) disable iff (!rst_an)
		alloc_en |-> !entry_valid[alloc_loc]);

endmodule

//--- design/cam_snoop_match.sv
`timescale 1ns/10ps
`include "cam_params.svh"

module cam_snoop_match (
	input  logic                  clk,
	input  logic                  rst_an,
	input  logic                  snoop_valid,
	input  cam_pkg::cam_key_t      snoop_key,
	input  cam_pkg::cam_entries_t  entries,
	input  logic [`CAM_DEPTH-1:0] entry_valid,
	output logic                  free_en,
	output cam_pkg::cam_loc_t      free_loc,
	output logic                  snoop_done,
	output logic                  snoop_hit,
	output cam_pkg::cam_data_t     snoop_data
);

	import cam_pkg::*;

	logic     hit_any;
	cam_loc_t hit_loc;

	// ==============================
	// Parallel compare on the low key bits. Scanning downwards lets the
	// lowest matching index win
	always_comb begin
		hit_any = 1'b0;
		hit_loc = '0;
		for (int i = `CAM_DEPTH - 1; i >= 0; i--) begin
			if (entry_valid[i] && cam_key_t'(entries[i]) == snoop_key) begin
				hit_any = 1'b1;
				hit_loc = cam_loc_t'(i);
			end
		end
	end

	// The hit location is released in the strobe cycle itself
	assign free_en = snoop_valid & hit_any;
	assign free_loc = hit_loc;

	// ==============================
	// One-cycle result register with zero data on a miss
	always_ff @(posedge clk or negedge rst_an) begin
		if (!rst_an) begin
			snoop_done <= 1'b0;
			snoop_hit <= 1'b0;
			snoop_data <= '0;
		end else begin
			snoop_done <= snoop_valid;
			snoop_hit <= free_en;
			snoop_data <= free_en ? entries[hit_loc] : '0;
		end
	end

	// A hit entry is gone in the cycle the result is presented
	a_hit_invalidates: assert property (@(posedge clk) disable iff (!rst_an)
		free_en |=> !entry_valid[$past(free_loc)]);

endmodule

//--- design/cam_top.sv
`timescale 1ns/10ps
`include "cam_params.svh"

module cam_top (
	input  logic              clk,
	input  logic              rst_an,
	input  logic              wr_valid,
	input  cam_pkg::cam_data_t wr_data,
	output logic              wr_ready,
	input  logic              snoop_valid,
	input  cam_pkg::cam_key_t  snoop_key,
	output logic              snoop_done,
	output logic              snoop_hit,
	output cam_pkg::cam_data_t snoop_data
);

	import cam_pkg::*;

	logic                  alloc_en;
	cam_loc_t              alloc_loc;
	logic                  free_en;
	cam_loc_t              free_loc;
	cam_entries_t          entries;
	logic [`CAM_DEPTH-1:0] entry_valid;

	// ==============================
	// Write side
	cam_loc_alloc cam_loc_alloc_inst (
		.clk       (clk),
		.rst_an    (rst_an),
		.wr_valid  (wr_valid),
		.wr_ready  (wr_ready),
		.alloc_en  (alloc_en),
		.alloc_loc (alloc_loc),
		.free_en   (free_en),
		.free_loc  (free_loc)
	);

	cam_entry_array cam_entry_array_inst (
		.clk         (clk),
		.rst_an      (rst_an),
		.alloc_en    (alloc_en),
		.alloc_loc   (alloc_loc),
		.wr_data     (wr_data),
		.free_en     (free_en),
		.free_loc    (free_loc),
		.entries     (entries),
		.entry_valid (entry_valid)
	);

	// ==============================
	// The snoop side feeds freed locations back to the allocator
	cam_snoop_match cam_snoop_match_inst (
		.clk         (clk),
		.rst_an      (rst_an),
		.snoop_valid (snoop_valid),
		.snoop_key   (snoop_key),
		.entries     (entries),
		.entry_valid (entry_valid),
		.free_en     (free_en),
		.free_loc    (free_loc),
		.snoop_done  (snoop_done),
		.snoop_hit   (snoop_hit),
		.snoop_data  (snoop_data)
	);

endmodule

//--- dv/cam_checker.sv
`timescale 1ns/10ps
`include "cam_params.svh"

module cam_checker (
	input  logic               clk,
	input  logic               rst_an,
	input  logic               wr_valid,
	input  cam_pkg::cam_data_t wr_data,
	input  logic               wr_ready,
	input  logic               snoop_valid,
	input  cam_pkg::cam_key_t  snoop_key,
	input  logic               snoop_done,
	input  logic               snoop_hit,
	input  cam_pkg::cam_data_t snoop_data,
	output int                 failed_tests
);

	import cam_pkg::*;

	// Model of the valid entries with one word per held key
	cam_key_t  model_keys[$];
	cam_data_t model_words[$];

	logic      exp_done;
	logic      exp_hit;
	cam_data_t exp_data;
	logic      model_ready;
	int        hit_idx;
	int        test_checks;
	int        test_errors;
	int        passed_tests;

	initial begin
		failed_tests = 0;
		passed_tests = 0;
		test_checks = 0;
		test_errors = 0;
	end

	function automatic int find_key(input cam_key_t key);
		int idx;
		idx = -1;
		for (int i = model_keys.size() - 1; i >= 0; i--) begin
			if (model_keys[i] == key) begin
				idx = i;
			end
		end
		return idx;
	endfunction

	task automatic compare(input string what, input cam_data_t got, input cam_data_t exp);
		test_checks++;
		if (got !== exp) begin
			test_errors++;
			$display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// ==============================
	// Outputs are compared between edges, then the model steps to the next edge
	always @(negedge clk) begin
		if (!rst_an) begin
			model_keys.delete();
			model_words.delete();
			exp_done = 1'b0;
			exp_hit = 1'b0;
			exp_data = '0;
		end else begin
			model_ready = (model_keys.size() < `CAM_DEPTH);
			compare("wr_ready", wr_ready, model_ready);
			compare("snoop_done", snoop_done, exp_done);
			compare("snoop_hit", snoop_hit, exp_hit);
			compare("snoop_data", snoop_data, exp_data);
			// The search sees the entries as they are before a same-cycle write
			hit_idx = snoop_valid ? find_key(snoop_key) : -1;
			exp_done = snoop_valid;
			exp_hit = (hit_idx >= 0);
			exp_data = exp_hit ? model_words[hit_idx] : '0;
			if (exp_hit) begin
				model_keys.delete(hit_idx);
				model_words.delete(hit_idx);
			end
			if (wr_valid && model_ready) begin
				model_keys.push_back(cam_key_t'(wr_data));
				model_words.push_back(wr_data);
			end
		end
	end

	task automatic report_test(input string name);
		if (test_errors == 0) begin
			passed_tests++;
			$display("%s: clean, %0d checks", name, test_checks);
		end else begin
			failed_tests++;
			$display("%s: %0d of %0d checks wrong", name, test_errors, test_checks);
		end
		test_checks = 0;
		test_errors = 0;
	endtask

	task automatic report_summary();
		$display("Summary: %0d tests clean, %0d tests with errors", passed_tests, failed_tests);
	endtask

endmodule

//--- dv/cam_tb.sv
`timescale 1ns/10ps
`include "cam_params.svh"

module cam_tb;

	import cam_pkg::*;

	localparam int RESET_CYCLES = 10;
	localparam int IDLE_CYCLES = 4;
	localparam int PHASE_A_CYCLES = 40;
	localparam int PHASE_B_CYCLES = 2000;
	// Roughly a fifth above the length of all phases together
	localparam int TIMEOUT_CYCLES = 2500;

	logic      clk;
	logic      rst_an;
	logic      wr_valid;
	cam_data_t wr_data;
	logic      wr_ready;
	logic      snoop_valid;
	cam_key_t  snoop_key;
	logic      snoop_done;
	logic      snoop_hit;
	cam_data_t snoop_data;
	int        failed_tests;
	int        cycle_count;
	int        write_seq;
	cam_key_t  cur_key;
	cam_key_t  held_q[$];
	cam_key_t  gone_q[$];

	cam_top cam_top_inst (
		.clk         (clk),
		.rst_an      (rst_an),
		.wr_valid    (wr_valid),
		.wr_data     (wr_data),
		.wr_ready    (wr_ready),
		.snoop_valid (snoop_valid),
		.snoop_key   (snoop_key),
		.snoop_done  (snoop_done),
		.snoop_hit   (snoop_hit),
		.snoop_data  (snoop_data)
	);

	cam_checker cam_checker (
		.clk          (clk),
		.rst_an       (rst_an),
		.wr_valid     (wr_valid),
		.wr_data      (wr_data),
		.wr_ready     (wr_ready),
		.snoop_valid  (snoop_valid),
		.snoop_key    (snoop_key),
		.snoop_done   (snoop_done),
		.snoop_hit    (snoop_hit),
		.snoop_data   (snoop_data),
		.failed_tests (failed_tests)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		cycle_count = 0;
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Test failed");
			$finish;
		end
	end

	// ==============================
	// One clock of stimulus. A write is held until accepted
	task automatic run_cycle(input int wr_pct, input bit snoops_on);
		logic     accepted;
		bit       new_write;
		int       pick;
		int       idx;
		cam_key_t key;
		@(negedge clk);
		accepted = wr_valid && wr_ready;
		@(posedge clk);
		new_write = 1'b0;
		if (accepted) begin
			held_q.push_back(cur_key);
		end
		if (accepted || !wr_valid) begin
			if ($urandom_range(0, 99) < wr_pct) begin
				// An odd multiplier keeps keys from repeating over the run
				cur_key = cam_key_t'(write_seq * 40503 + 4660);
				write_seq++;
				new_write = 1'b1;
				wr_valid <= 1'b1;
				wr_data <= {32'($urandom), 16'($urandom), cur_key};
			end else begin
				wr_valid <= 1'b0;
			end
		end
		if (snoops_on && $urandom_range(0, 99) < 60) begin
			pick = $urandom_range(0, 3);
			if (pick < 2 && held_q.size() > 0) begin
				idx = $urandom_range(0, held_q.size() - 1);
				key = held_q[idx];
				held_q.delete(idx);
				gone_q.push_back(key);
				if (gone_q.size() > 32) begin
					void'(gone_q.pop_front());
				end
			end else if (pick == 2 && gone_q.size() > 0) begin
				key = gone_q[$urandom_range(0, gone_q.size() - 1)];
			end else if (new_write && $urandom_range(0, 1) == 1) begin
				key = cur_key;
			end else begin
				key = cam_key_t'($urandom);
			end
			snoop_valid <= 1'b1;
			snoop_key <= key;
		end else begin
			snoop_valid <= 1'b0;
		end
	endtask

	initial begin
		void'($urandom(40));
		rst_an = 1'b0;
		wr_valid = 1'b0;
		wr_data = '0;
		snoop_valid = 1'b0;
		snoop_key = '0;
		write_seq = 0;
		cur_key = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_an <= 1'b1;
		repeat (IDLE_CYCLES) run_cycle(0, 1'b0);
		cam_checker.report_test("reset_idle");
		repeat (PHASE_A_CYCLES) run_cycle(100, 1'b0);
		cam_checker.report_test("fill_and_stall");
		repeat (PHASE_B_CYCLES) run_cycle(70, 1'b1);
		repeat (IDLE_CYCLES) run_cycle(0, 1'b0);
		cam_checker.report_test("random_traffic");
		cam_checker.report_summary();
		if (failed_tests == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- sim.f
+incdir+design
design/cam_pkg.sv
design/cam_free_fifo.sv
design/cam_loc_alloc.sv
design/cam_entry_array.sv
design/cam_snoop_match.sv
design/cam_top.sv
dv/cam_checker.sv
dv/cam_tb.sv
